// File: src/memShare_settings.svh
/*
  Sizes for the shared-memory controller. The arbiter queue must hold one entry per client,
  so QUEUE_DEPTH may not be smaller than NUM_CLIENTS.
*/
`ifndef MEMSHARE_SETTINGS_SVH
`define MEMSHARE_SETTINGS_SVH

// Memory geometry, 256 words of 32 bits
`define MEM_ADDR_W 8
`define DATA_W 32

// Reader plus two incrementers
`define NUM_CLIENTS 3

// One slot per client is enough, since a client queues once per request
`define QUEUE_DEPTH 3

// Word shared by every client as the counter
`define COUNTER_ADDR 8'h10

`endif

// File: src/memSharePkg.sv
/*
  Shared types for the memory controller. Widths come from the settings header, so the header
  must be on the include path when this package is compiled.
*/
`include "memShare_settings.svh"

package memSharePkg;

  // One memory word and one memory address
  typedef logic [`DATA_W-1:0] memData_t;
  typedef logic [`MEM_ADDR_W-1:0] memAddr_t;

  // A single memory access as a client presents it to the arbiter
  // Enable low means no access in this cycle
  typedef struct packed {
    logic enable;
    logic write;
    memAddr_t addr;
    memData_t wdata;
  } memReq_t;

  // Bit 0 is the reader, bits 1 and 2 are incrementers 0 and 1
  typedef logic [`NUM_CLIENTS-1:0] clientMask_t;

  // Display position with 4 rows of 16 characters
  typedef struct packed {
    logic [1:0] row;
    logic [3:0] col;
  } charPos_t;

  // One ASCII character
  typedef logic [7:0] asciiChar_t;

endpackage

// File: src/memArbiter.sv
/*
  FIFO arbiter for three clients. A client must hold its request level until its last access
  ends; the grant clears one cycle after the request falls.
*/
`include "memShare_settings.svh"

module memArbiter (
  input  logic                    EXT_CLK,
  input  logic                    rstN,
  input  memSharePkg::clientMask_t reqLevel,
  input  memSharePkg::memReq_t    clientReq0,
  input  memSharePkg::memReq_t    clientReq1,
  input  memSharePkg::memReq_t    clientReq2,
  output memSharePkg::clientMask_t grant,
  output memSharePkg::memReq_t    memReq
);
  import memSharePkg::*;

  localparam int IDX_W = $clog2(`NUM_CLIENTS);
  localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

  // Queue of client indices with the head in entry 0
  logic [IDX_W-1:0] queueQ [`QUEUE_DEPTH];
  logic [IDX_W-1:0] queueN [`QUEUE_DEPTH];
  logic [CNT_W-1:0] countQ;
  logic [CNT_W-1:0] countN;

  clientMask_t reqPrevQ;
  clientMask_t reqRise;
  clientMask_t grantN;

  // A client joins the queue only on the rising edge of its request
  assign reqRise = reqLevel & ~reqPrevQ;

  always_comb begin
    queueN = queueQ;
    countN = countQ;
    // A held grant survives only while its request stays high
    grantN = grant & reqLevel;
    // Lower index pushes first when several requests rise together
    for (int i = 0; i < `NUM_CLIENTS; i++) begin
      if (reqRise[i] && (countN < CNT_W'(`QUEUE_DEPTH))) begin
        queueN[countN] = IDX_W'(i);
        countN = countN + 1'b1;
      end
    end
    // With the memory free the head is granted in the same cycle
    // This bypass gives a one-cycle grant when the queue was empty
    if ((grant == '0) && (countN != '0)) begin
      grantN = '0;
      grantN[queueN[0]] = 1'b1;
      for (int j = 0; j < `QUEUE_DEPTH - 1; j++) begin
        queueN[j] = queueN[j + 1];
      end
      queueN[`QUEUE_DEPTH - 1] = '0;
      countN = countN - 1'b1;
    end
  end

  always_ff @(posedge EXT_CLK) begin
    if (!rstN) begin
      reqPrevQ <= '0;
      countQ <= '0;
      grant <= '0;
    end else begin
      reqPrevQ <= reqLevel;
      countQ <= countN;
      grant <= grantN;
    end
  end

  // Queue storage moves one slot toward the head on each pop
  always_ff @(posedge EXT_CLK) begin
    queueQ <= queueN;
  end

  // Only the granted client reaches the memory
  // Enable stays low while nobody holds the grant
  always_comb begin
    memReq = '0;
    if (grant[0]) begin
      memReq = clientReq0;
    end else if (grant[1]) begin
      memReq = clientReq1;
    end else if (grant[2]) begin
      memReq = clientReq2;
    end
  end

endmodule

// File: src/sharedMemory.sv
/*
  256 by 32 single-port memory with a registered read. Contents start at zero
  and are kept across reset.
*/
`include "memShare_settings.svh"

module sharedMemory (
  input  logic                 EXT_CLK,
  input  memSharePkg::memReq_t memReq,
  output memSharePkg::memData_t rdata
);
  import memSharePkg::*;

  memData_t memArray [2**`MEM_ADDR_W];

  // Power-up contents, the counter starts from zero
  initial begin
    for (int i = 0; i < 2**`MEM_ADDR_W; i++) begin
      memArray[i] = '0;
    end
  end

  always_ff @(posedge EXT_CLK) begin
    if (memReq.enable && memReq.write) begin
      memArray[memReq.addr] <= memReq.wdata;
    end
  end

  // Read data shows up the cycle after the read request
  // It holds its value until the next read
  always_ff @(posedge EXT_CLK) begin
    if (memReq.enable && !memReq.write) begin
      rdata <= memArray[memReq.addr];
    end
  end

endmodule

// File: src/atomicIncrementer.sv
/*
  Adds one to the counter word while holding a single grant. A start pulse is ignored
  unless the FSM is idle.
*/
`include "memShare_settings.svh"

module atomicIncrementer (
  input  logic                  EXT_CLK,
  input  logic                  rstN,
  input  logic                  start,
  input  logic                  grant,
  input  memSharePkg::memData_t rdata,
  output logic                  reqLevel,
  output memSharePkg::memReq_t  clientReq,
  output logic                  done
);
  import memSharePkg::*;

  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    READ,
    WAIT,
    WRITE
  } incState_t;

  incState_t stateQ;
  incState_t stateN;
  memData_t  sumQ;

  always_comb begin
    stateN = stateQ;
    case (stateQ)
      IDLE:    if (start) stateN = REQUEST;
      REQUEST: if (grant) stateN = READ;
      // Read data lands in WAIT, write goes out the cycle after
      READ:    stateN = WAIT;
      WAIT:    stateN = WRITE;
      WRITE:   stateN = IDLE;
      default: stateN = IDLE;
    endcase
  end

  always_ff @(posedge EXT_CLK) begin
    if (!rstN) begin
      stateQ <= IDLE;
      reqLevel <= 1'b0;
      done <= 1'b0;
    end else begin
      stateQ <= stateN;
      // Request stays up from REQUEST through WRITE, so no other client can slip in
      reqLevel <= (stateN != IDLE);
      // Done pulses in the same cycle the request drops
      done <= (stateQ == WRITE);
    end
  end

  // Incremented value is taken while the read data is valid
  always_ff @(posedge EXT_CLK) begin
    if (stateQ == WAIT) begin
      sumQ <= rdata + 1'b1;
    end
  end

  // Accesses are issued only in states reached after the grant
  always_comb begin
    clientReq.enable = (stateQ == READ) || (stateQ == WRITE);
    clientReq.write = (stateQ == WRITE);
    clientReq.addr = `COUNTER_ADDR;
    clientReq.wdata = sumQ;
  end

endmodule

// File: src/memoryReader.sv
/*
  Reads the counter word once per start pulse and holds the result until the next read.
  A start pulse is ignored unless the FSM is idle.
*/
`include "memShare_settings.svh"

module memoryReader (
  input  logic                  EXT_CLK,
  input  logic                  rstN,
  input  logic                  start,
  input  logic                  grant,
  input  memSharePkg::memData_t rdata,
  output logic                  reqLevel,
  output memSharePkg::memReq_t  clientReq,
  output logic                  readValid,
  output memSharePkg::memData_t readValue
);
  import memSharePkg::*;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    READ,
    CAPTURE
  } rdState_t;

  rdState_t stateQ;
  rdState_t stateN;

  always_comb begin
    stateN = stateQ;
    case (stateQ)
      IDLE:    if (start) stateN = REQUEST;
      REQUEST: if (grant) stateN = READ;
      READ:    stateN = CAPTURE;
      CAPTURE: stateN = IDLE;
      default: stateN = IDLE;
    endcase
  end

  always_ff @(posedge EXT_CLK) begin
    if (!rstN) begin
      stateQ <= IDLE;
      reqLevel <= 1'b0;
      readValid <= 1'b0;
      readValue <= '0;
    end else begin
      stateQ <= stateN;
      reqLevel <= (stateN != IDLE);
      readValid <= (stateQ == CAPTURE);
      // Memory data is valid in CAPTURE, one cycle after the read
      if (stateQ == CAPTURE) begin
        readValue <= rdata;
      end
    end
  end

  // Single read access, never a write
  always_comb begin
    clientReq.enable = (stateQ == READ);
    clientReq.write = 1'b0;
    clientReq.addr = `COUNTER_ADDR;
    clientReq.wdata = '0;
  end

endmodule

// File: src/hexCharFormatter.sv
/*
  Row 0 shows "0x" and eight uppercase hex digits of value; every other position is a space.
  The character is registered, one cycle behind charPos.
*/
module hexCharFormatter (
  input  logic                    EXT_CLK,
  input  logic                    rstN,
  input  memSharePkg::charPos_t   charPos,
  input  memSharePkg::memData_t   value,
  output memSharePkg::asciiChar_t charCode
);
  import memSharePkg::*;

  logic [2:0] nibIdx;
  memData_t   shifted;

  // Digit ASCII for one nibble
  function automatic asciiChar_t nibbleChar(input logic [3:0] nib);
    // '0' is 48, and 'A' minus ten is 55
    if (nib <= 4'd9) begin
      return 8'd48 + {4'd0, nib};
    end
    return 8'd55 + {4'd0, nib};
  endfunction

  // Column 2 holds the top nibble and column 9 the bottom one
  assign nibIdx = 3'(4'd9 - charPos.col);
  assign shifted = value >> {nibIdx, 2'b00};

  always_ff @(posedge EXT_CLK) begin
    if (!rstN) begin
      charCode <= " ";
    end else if (charPos.row != 2'd0) begin
      charCode <= " ";
    end else if (charPos.col == 4'd0) begin
      charCode <= "0";
    end else if (charPos.col == 4'd1) begin
      charCode <= "x";
    end else if (charPos.col <= 4'd9) begin
      charCode <= nibbleChar(shifted[3:0]);
    end else begin
      charCode <= " ";
    end
  end

endmodule

// File: src/memShareTop.sv
/*
  Three clients share one memory through a FIFO arbiter. incStart bit 0 drives incrementer 0
  and bit 1 drives incrementer 1; start pulses to a busy client are dropped.
*/
module memShareTop (
  input  logic                    EXT_CLK,
  input  logic                    rstN,
  input  logic [1:0]              incStart,
  input  logic                    readStart,
  output logic [1:0]              incDone,
  output logic                    readValid,
  output memSharePkg::memData_t   readValue,
  input  memSharePkg::charPos_t   charPos,
  output memSharePkg::asciiChar_t charCode
);
  import memSharePkg::*;

  clientMask_t reqLevel;
  clientMask_t grant;
  memReq_t     clientReq [3];
  memReq_t     memReq;
  memData_t    rdata;

  // Client 0 reads the counter for display
  memoryReader uReader (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .start(readStart),
    .grant(grant[0]),
    .rdata(rdata),
    .reqLevel(reqLevel[0]),
    .clientReq(clientReq[0]),
    .readValid(readValid),
    .readValue(readValue)
  );

  // Clients 1 and 2 both bump the same counter
  atomicIncrementer uInc0 (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .start(incStart[0]),
    .grant(grant[1]),
    .rdata(rdata),
    .reqLevel(reqLevel[1]),
    .clientReq(clientReq[1]),
    .done(incDone[0])
  );

  atomicIncrementer uInc1 (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .start(incStart[1]),
    .grant(grant[2]),
    .rdata(rdata),
    .reqLevel(reqLevel[2]),
    .clientReq(clientReq[2]),
    .done(incDone[1])
  );

  memArbiter uArbiter (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .reqLevel(reqLevel),
    .clientReq0(clientReq[0]),
    .clientReq1(clientReq[1]),
    .clientReq2(clientReq[2]),
    .grant(grant),
    .memReq(memReq)
  );

  // Read data fans out to every client, only the granted one uses it
  sharedMemory uMemory (
    .EXT_CLK(EXT_CLK),
    .memReq(memReq),
    .rdata(rdata)
  );

  hexCharFormatter uFormatter (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .charPos(charPos),
    .value(readValue),
    .charCode(charCode)
  );

endmodule

// File: verif/tbClockGen.sv
/*
  Free-running 10 ns clock. rstN is held low over the first 2 rising edges.
*/
module tbClockGen (
  output logic EXT_CLK,
  output logic rstN
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    EXT_CLK = 1'b0;
    forever #5 EXT_CLK = ~EXT_CLK;
  end

  // Reset is released on a falling edge, half a cycle clear of the sampling edge
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge EXT_CLK);
    @(negedge EXT_CLK);
    rstN = 1'b1;
  end
endmodule

// File: verif/memShare_checker.sv
/*
  Arbiter assertions, bound into every memArbiter. A grant may outlive its request by
  one cycle, because the arbiter clears it on the edge after the request falls.
*/
module memShareChecker (
  input logic                     EXT_CLK,
  input logic                     rstN,
  input memSharePkg::clientMask_t reqLevel,
  input memSharePkg::clientMask_t grant
);
  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures seen so far
  int unsigned failCount = 0;

  // At most one client owns the memory at a time
  grantOneHot: assert property (@(posedge EXT_CLK) disable iff (!rstN) $onehot0(grant))
    else begin
      failCount++;
      $error("grant is not zero or one-hot: %b", grant);
    end

  // Each grant bit is backed by its request on this edge or the one before
  grantHasReq: assert property (@(posedge EXT_CLK) disable iff (!rstN)
    (grant & ~reqLevel & ~$past(reqLevel)) == '0)
    else begin
      failCount++;
      $error("grant %b held without request %b", grant, reqLevel);
    end

  // Reset leaves every grant low
  grantResetLow: assert property (@(posedge EXT_CLK) !rstN |=> (grant == '0))
    else begin
      failCount++;
      $error("grant %b not cleared after reset", grant);
    end
endmodule

bind memArbiter memShareChecker uChecker (
  .EXT_CLK(EXT_CLK),
  .rstN(rstN),
  .reqLevel(reqLevel),
  .grant(grant)
);

// File: verif/memShareTb.sv
/*
  Random starts on all three clients, checked against a counter model. The model keeps its
  own busy flags and treats a start to a busy client as ignored, as the clients do.
*/
module memShareTb;
  timeunit 1ns;
  timeprecision 1ps;
  import memSharePkg::*;

  localparam int NUM_ROUNDS = 16;
  // 40 cycles per round, and the margin covers the fixed tests
  localparam int WATCHDOG_CYCLES = NUM_ROUNDS * 40 + 1000;

  logic       EXT_CLK;
  logic       rstN;
  logic [1:0] incStart;
  logic       readStart;
  logic [1:0] incDone;
  logic       readValid;
  memData_t   readValue;
  charPos_t   charPos;
  asciiChar_t charCode;

  // Model state holds the expected counter and which clients are mid-transaction
  integer     seed;
  memData_t   expCount;
  logic [1:0] incBusy;
  logic       rdBusy;
  int         errCount;
  int         passTests;
  int         failTests;

  tbClockGen uClock (.EXT_CLK(EXT_CLK), .rstN(rstN));

  memShareTop u_dut (
    .EXT_CLK(EXT_CLK),
    .rstN(rstN),
    .incStart(incStart),
    .readStart(readStart),
    .incDone(incDone),
    .readValid(readValid),
    .readValue(readValue),
    .charPos(charPos),
    .charCode(charCode)
  );

  task automatic checkData(input string name, input memData_t got, input memData_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkChar(input string name, input asciiChar_t got, input asciiChar_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
      errCount++;
    end
  endtask

  // Row 0 reads "0x" then eight uppercase digits, and all else is blank
  function automatic asciiChar_t expectedChar(input charPos_t pos, input memData_t val);
    string hexDigits = "0123456789ABCDEF";
    int digit;
    if (pos.row != 2'd0 || pos.col > 4'd9) return " ";
    if (pos.col == 4'd0) return "0";
    if (pos.col == 4'd1) return "x";
    digit = int'((val >> (4 * (9 - int'(pos.col)))) & 32'hF);
    return hexDigits[digit];
  endfunction

  // Each cycle observes done pulses at the falling edge, updates the model, then drives starts
  task automatic cycleStep(input logic [1:0] incReq, input logic rdReq);
    @(negedge EXT_CLK);
    for (int i = 0; i < 2; i++) begin
      if (incDone[i]) begin
        if (!incBusy[i]) begin
          $display("Incrementer %0d pulsed done without an accepted start", i);
          errCount++;
        end
        incBusy[i] = 1'b0;
        expCount = expCount + 1;
      end
    end
    if (readValid) begin
      if (!rdBusy) begin
        $display("Reader pulsed readValid without an accepted start");
        errCount++;
      end
      rdBusy = 1'b0;
    end
    // A client that finished this cycle is idle again by the next rising edge
    incStart = incReq;
    readStart = rdReq;
    incBusy = incBusy | incReq;
    rdBusy = rdBusy | rdReq;
  endtask

  task automatic waitIdle();
    while (incBusy != 2'b00 || rdBusy) begin
      cycleStep(2'b00, 1'b0);
    end
  endtask

  // With every client idle the read value must match the model exactly
  task automatic doRead();
    cycleStep(2'b00, 1'b1);
    waitIdle();
    checkData("readValue", readValue, expCount);
  endtask

  task automatic checkDisplay(input int count, input logic sweep);
    logic [31:0] r;
    charPos_t pos;
    for (int n = 0; n < count; n++) begin
      r = $random(seed);
      pos.row = sweep ? 2'(n >> 4) : (r[8] ? 2'd0 : r[1:0]);
      pos.col = sweep ? 4'(n) : r[5:2];
      charPos = pos;
      @(negedge EXT_CLK);
      checkChar("charCode", charCode, expectedChar(pos, expCount));
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errCount == errBefore) begin
      passTests++;
      $display("PASS  %s", name);
    end else begin
      failTests++;
      $display("FAIL  %s (%0d errors)", name, errCount - errBefore);
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge EXT_CLK);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

  initial begin
    int errBefore;
    memData_t base;
    logic [31:0] r;
    seed = 32'hc2d66ca2;
    incStart = 2'b00;
    readStart = 1'b0;
    charPos = '0;
    expCount = '0;
    incBusy = 2'b00;
    rdBusy = 1'b0;
    errCount = 0;
    passTests = 0;
    failTests = 0;
    @(posedge rstN);

    errBefore = errCount;
    doRead();
    checkDisplay(64, 1'b1);
    finishTest("reset value and blank display", errBefore);

    // Eight lone increments at random gaps on a random incrementer
    errBefore = errCount;
    base = expCount;
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      repeat (r[2:0]) cycleStep(2'b00, 1'b0);
      cycleStep(r[3] ? 2'b10 : 2'b01, 1'b0);
      waitIdle();
    end
    checkData("incDone count", expCount, base + 8);
    doRead();
    finishTest("single increments", errBefore);

    // Both incrementers race on the same word, so a lost update would show as +1
    errBefore = errCount;
    base = expCount;
    cycleStep(2'b11, 1'b0);
    waitIdle();
    doRead();
    checkData("readValue", readValue, base + 2);
    finishTest("paired increments", errBefore);

    errBefore = errCount;
    for (int rnd = 0; rnd < NUM_ROUNDS; rnd++) begin
      repeat (6) begin
        r = $random(seed);
        cycleStep({r[3:2] == 2'b00, r[1:0] == 2'b00}, r[5:4] == 2'b00);
      end
      waitIdle();
      doRead();
      checkDisplay(2, 1'b0);
    end
    finishTest("mixed random rounds", errBefore);

    errBefore = errCount;
    repeat (6) begin
      r = $random(seed);
      cycleStep({r[0], ~r[0]}, 1'b0);
      waitIdle();
      doRead();
      checkDisplay(8, 1'b0);
    end
    finishTest("hex display", errBefore);

    if (u_dut.uArbiter.uChecker.failCount != 0) begin
      $display("Arbiter assertions failed %0d times", u_dut.uArbiter.uChecker.failCount);
      errCount += int'(u_dut.uArbiter.uChecker.failCount);
    end

    $display("Tests: %0d passed, %0d failed, %0d check errors", passTests, failTests, errCount);
    if (errCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end
endmodule

// File: memShareTop.f
+incdir+src
src/memSharePkg.sv
src/memArbiter.sv
src/sharedMemory.sv
src/atomicIncrementer.sv
src/memoryReader.sv
src/hexCharFormatter.sv
src/memShareTop.sv
verif/tbClockGen.sv
verif/memShare_checker.sv
verif/memShareTb.sv

// File: Makefile
BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module memShareTb \
		-f memShareTop.f --Mdir $(BUILD_DIR) -o simv
	@out="$$(./$(BUILD_DIR)/simv)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(BUILD_DIR)
